/* design/bitparse_params.svh */
`ifndef BITPARSE_PARAMS_SVH
`define BITPARSE_PARAMS_SVH

// codec word from the show-ahead source
`define BP_WORD_W 128

// bit buffer, three codec words deep
`define BP_BUF_W 384

// read a new word while fewer bits than this remain
`define BP_REFILL_LEVEL 256

// head window handed to the block parser
`define BP_WIN_W 160

// worst case block
// 4 mode + 3 flatness + 1 csc + 3 step + 16 x 8 residual bits
`define BP_MAX_BLK_BITS 139

// fullness and bit count width, holds up to BP_BUF_W
`define BP_FULL_W 9

// residuals per block
`define BP_NUM_PX 16

// component bit depth, fixed
`define BP_BIT_DEPTH 8

`endif

/* design/bitparse_pkg.sv */
`include "bitparse_params.svh"

package bitparse_pkg;

  // block coding mode
  // encoding 3 is never produced by the header decode
  typedef enum logic [1:0]
  {
    xfm = 2'd0,
    bp  = 2'd1,
    mpp = 2'd2
  } blk_mode_e;

  // flatness type, flat_none when the flag bit is clear
  typedef enum logic [2:0]
  {
    flat_0    = 3'd0,
    flat_1    = 3'd1,
    flat_2    = 3'd2,
    flat_3    = 3'd3,
    flat_none = 3'd4
  } flat_type_e;

  // mpp colour space, source is rgb so the bit is always coded
  typedef enum logic
  {
    csc_rgb   = 1'b0,
    csc_ycocg = 1'b1
  } csc_e;

  // residuals right-aligned, element 0 is the first field in the stream
  typedef logic [`BP_NUM_PX-1:0][`BP_BIT_DEPTH-1:0] quant_arr_t;

endpackage

/* design/bit_funnel.sv */
`timescale 1ns/1ps
`include "bitparse_params.svh"

module bit_funnel
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start_dec,
  input  logic [`BP_WORD_W-1:0] codec_data,
  input  logic [`BP_FULL_W-1:0] consume_bits,
  output logic                  codec_data_rd_en,
  output logic [`BP_WIN_W-1:0]  win_bits,
  output logic                  win_vld
);

  localparam logic [`BP_FULL_W-1:0] WORD_BITS = `BP_WORD_W;

  // left-aligned bit buffer, oldest bit at the msb
  logic [`BP_BUF_W-1:0]  buf_q;
  logic [`BP_BUF_W-1:0]  buf_shl;
  logic [`BP_BUF_W-1:0]  keep_mask;
  logic [`BP_BUF_W-1:0]  word_pos;
  logic [`BP_BUF_W-1:0]  buf_d;
  logic [`BP_FULL_W-1:0] fullness_q;
  logic [`BP_FULL_W-1:0] fullness_left;
  logic [`BP_FULL_W-1:0] fullness_d;

  // bits still held once this cycle's block is gone
  assign fullness_left = fullness_q - consume_bits;

  // refill decision uses the post-consume level, same cycle
  assign codec_data_rd_en = start_dec && (fullness_left < `BP_REFILL_LEVEL);

  assign fullness_d = codec_data_rd_en ? fullness_left + WORD_BITS : fullness_left;

  // drop the consumed bits off the top
  assign buf_shl = buf_q << consume_bits;

  // only the remaining bits survive
  // anything below them is stale and gets cleared
  assign keep_mask = ~({`BP_BUF_W{1'b1}} >> fullness_left);

  // new word lands right behind the remaining bits
  // fullness_left < 256 here so the word never falls off the end
  assign word_pos = {codec_data, {(`BP_BUF_W-`BP_WORD_W){1'b0}}} >> fullness_left;

  assign buf_d = (buf_shl & keep_mask) | (codec_data_rd_en ? word_pos : '0);

  always_ff @(posedge clk)
  begin
    buf_q <= buf_d;
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      fullness_q <= '0;
    end
    else
    begin
      fullness_q <= fullness_d;
    end
  end

  // parser sees the head of the buffer
  assign win_bits = buf_q[`BP_BUF_W-1 -: `BP_WIN_W];

  // a whole block of any kind is guaranteed present
  assign win_vld = (fullness_q >= `BP_MAX_BLK_BITS);

  // refill level keeps the buffer from overflowing
  a_fullness_max: assert property (
    @(posedge clk) disable iff (!rstn)
    fullness_q <= `BP_BUF_W
  ) else $error("bit buffer fullness %0d above capacity", fullness_q);

  // parser never takes bits that are not buffered yet
  a_consume_le_fullness: assert property (
    @(posedge clk) disable iff (!rstn)
    consume_bits <= fullness_q
  ) else $error("consume %0d exceeds fullness %0d", consume_bits, fullness_q);

endmodule

/* design/mpp_suffix_decoder.sv */
`timescale 1ns/1ps
`include "bitparse_params.svh"

module mpp_suffix_decoder
  import bitparse_pkg::*;
(
  input  logic [`BP_WORD_W-1:0] suffix_bits,
  input  logic [2:0]            suffix_step,
  output quant_arr_t            quant,
  output logic [`BP_FULL_W-1:0] qres_size
);

  localparam logic [3:0]            DEPTH  = `BP_BIT_DEPTH;
  localparam logic [`BP_FULL_W-1:0] NUM_PX = `BP_NUM_PX;

  // width of one residual field, 1 to 8 bits
  logic [3:0]            fld_w;
  // suffix with field i moved to the msb
  logic [`BP_WORD_W-1:0] fld_sh [`BP_NUM_PX];

  assign fld_w = DEPTH - {1'b0, suffix_step};

  // all fields have the same width
  assign qres_size = NUM_PX * {{(`BP_FULL_W-4){1'b0}}, fld_w};

  always_comb
  begin
    for (int i = 0; i < `BP_NUM_PX; i++)
    begin
      // field i starts i widths below the top
      fld_sh[i] = suffix_bits << (i * fld_w);
      // top 8 bits hold the field msb first
      // dropping step lsbs right-aligns it and zero-extends
      quant[i] = fld_sh[i][`BP_WORD_W-1 -: `BP_BIT_DEPTH] >> suffix_step;
    end
  end

endmodule

/* design/block_parser.sv */
`timescale 1ns/1ps
`include "bitparse_params.svh"

module block_parser
  import bitparse_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [`BP_WIN_W-1:0]  win_bits,
  input  logic                  win_vld,
  output logic [`BP_FULL_W-1:0] consume_bits,
  output logic [`BP_WORD_W-1:0] suffix_bits,
  output logic [2:0]            suffix_step,
  input  quant_arr_t            quant,
  input  logic [`BP_FULL_W-1:0] qres_size,
  output logic                  blk_vld,
  output blk_mode_e             blk_mode,
  output flat_type_e            blk_flat,
  output csc_e                  blk_csc,
  output logic [2:0]            blk_step,
  output quant_arr_t            blk_quant
);

  // msb of the window is the first unread bit
  localparam int TOP = `BP_WIN_W - 1;

  blk_mode_e            prev_mode;
  blk_mode_e            mode_nxt;
  logic                 same_flag;
  logic [1:0]           mode_val;
  logic [2:0]           mode_len;
  logic [`BP_WIN_W-1:0] after_mode;
  logic                 flat_flag;
  flat_type_e           flat_nxt;
  logic [2:0]           flat_len;
  logic [3:0]           hdr_len;
  logic [3:0]           mpp_hdr_len;
  logic [`BP_WIN_W-1:0] after_hdr;
  logic [`BP_WIN_W-1:0] after_mpp_hdr;
  csc_e                 csc_nxt;
  logic                 is_mpp;

  assign same_flag = win_bits[TOP];
  assign mode_val  = win_bits[TOP-1 -: 2];

  // mode field, 1, 3 or 4 bits
  always_comb
  begin
    if (same_flag)
    begin
      mode_nxt = prev_mode;
      mode_len = 3'd1;
    end
    else if (mode_val == 2'd3)
    begin
      // escape, one more bit picks xfm or bp
      mode_nxt = win_bits[TOP-3] ? bp : xfm;
      mode_len = 3'd4;
    end
    else
    begin
      mode_nxt = blk_mode_e'(mode_val);
      mode_len = 3'd3;
    end
  end

  // flatness flag plus optional 2-bit type
  assign after_mode = win_bits << mode_len;
  assign flat_flag  = after_mode[TOP];
  assign flat_nxt   = flat_flag ? flat_type_e'({1'b0, after_mode[TOP-1 -: 2]}) : flat_none;
  assign flat_len   = flat_flag ? 3'd3 : 3'd1;
  assign hdr_len    = {1'b0, mode_len} + {1'b0, flat_len};
  assign is_mpp     = (mode_nxt == mpp);

  // mpp only: csc bit then 3-bit step size
  assign after_hdr   = win_bits << hdr_len;
  assign csc_nxt     = after_hdr[TOP] ? csc_ycocg : csc_rgb;
  assign suffix_step = after_hdr[TOP-1 -: 3];

  // residual fields start right after csc and step
  assign mpp_hdr_len   = hdr_len + 4'd4;
  assign after_mpp_hdr = win_bits << mpp_hdr_len;
  assign suffix_bits   = after_mpp_hdr[TOP -: `BP_WORD_W];

  // xfm and bp give back only mode and flatness bits
  always_comb
  begin
    if (!win_vld)
      consume_bits = '0;
    else if (is_mpp)
      consume_bits = {{(`BP_FULL_W-4){1'b0}}, mpp_hdr_len} + qres_size;
    else
      consume_bits = {{(`BP_FULL_W-4){1'b0}}, hdr_len};
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      prev_mode <= xfm;
      blk_vld   <= 1'b0;
    end
    else
    begin
      blk_vld <= win_vld;
      // same flag of the next block refers to this one
      if (win_vld)
        prev_mode <= mode_nxt;
    end
  end

  // block record, one cycle after the header was at the head
  always_ff @(posedge clk)
  begin
    if (win_vld)
    begin
      blk_mode  <= mode_nxt;
      blk_flat  <= flat_nxt;
      blk_csc   <= is_mpp ? csc_nxt : csc_rgb;
      blk_step  <= is_mpp ? suffix_step : 3'd0;
      blk_quant <= is_mpp ? quant : '0;
    end
  end

  // registered mode stays in the legal set, including same-flag reuse
  a_blk_mode_legal: assert property (
    @(posedge clk) disable iff (!rstn)
    blk_vld |-> blk_mode inside {xfm, bp, mpp}
  ) else $error("illegal block mode %0d", blk_mode);

endmodule

/* design/bitparse_top.sv */
`timescale 1ns/1ps
`include "bitparse_params.svh"

module bitparse_top
  import bitparse_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start_dec,
  input  logic [`BP_WORD_W-1:0] codec_data,
  output logic                  codec_data_rd_en,
  output logic                  blk_vld,
  output blk_mode_e             blk_mode,
  output flat_type_e            blk_flat,
  output csc_e                  blk_csc,
  output logic [2:0]            blk_step,
  output quant_arr_t            blk_quant
);

  // funnel to parser
  logic [`BP_WIN_W-1:0]  win_bits;
  logic                  win_vld;
  // parser back to funnel, same cycle
  logic [`BP_FULL_W-1:0] consume_bits;
  // parser to suffix decoder and back
  logic [`BP_WORD_W-1:0] suffix_bits;
  logic [2:0]            suffix_step;
  quant_arr_t            quant;
  logic [`BP_FULL_W-1:0] qres_size;

  bit_funnel i_bit_funnel
  (
    .clk              (clk),
    .rstn             (rstn),
    .start_dec        (start_dec),
    .codec_data       (codec_data),
    .consume_bits     (consume_bits),
    .codec_data_rd_en (codec_data_rd_en),
    .win_bits         (win_bits),
    .win_vld          (win_vld)
  );

  block_parser i_block_parser
  (
    .clk          (clk),
    .rstn         (rstn),
    .win_bits     (win_bits),
    .win_vld      (win_vld),
    .consume_bits (consume_bits),
    .suffix_bits  (suffix_bits),
    .suffix_step  (suffix_step),
    .quant        (quant),
    .qres_size    (qres_size),
    .blk_vld      (blk_vld),
    .blk_mode     (blk_mode),
    .blk_flat     (blk_flat),
    .blk_csc      (blk_csc),
    .blk_step     (blk_step),
    .blk_quant    (blk_quant)
  );

  mpp_suffix_decoder i_mpp_suffix_decoder
  (
    .suffix_bits (suffix_bits),
    .suffix_step (suffix_step),
    .quant       (quant),
    .qres_size   (qres_size)
  );

endmodule

/* bench/bitparse_tb.sv */
`timescale 1ns/1ps
`include "bitparse_params.svh"

module bitparse_tb;

  // idle cycles after reset, then quiet cycles after the last block
  localparam int IDLE_CYCLES  = 6;
  localparam int DRAIN_CYCLES = 16;

  logic                  clk;
  logic                  rstn;
  logic                  start_dec;
  logic [`BP_WORD_W-1:0] codec_data;
  logic                  codec_data_rd_en;
  logic                  blk_vld;
  logic [1:0]            blk_mode;
  logic [2:0]            blk_flat;
  logic                  blk_csc;
  logic [2:0]            blk_step;
  logic [127:0]          blk_quant;

  // trace contents
  logic [127:0] words [$];
  string        exp_name [$];
  int           exp_mode [$];
  int           exp_flat [$];
  int           exp_csc [$];
  int           exp_step [$];
  logic [127:0] exp_quant [$];

  int   word_idx;
  int   blk_seen;
  int   err_count;
  int   tests_passed;
  int   tests_failed;
  int   rand_seed;
  logic rd_seen;
  logic streaming;
  logic load_ok;

  bitparse_top i_bitparse_top
  (
    .clk              (clk),
    .rstn             (rstn),
    .start_dec        (start_dec),
    .codec_data       (codec_data),
    .codec_data_rd_en (codec_data_rd_en),
    .blk_vld          (blk_vld),
    .blk_mode         (blk_mode),
    .blk_flat         (blk_flat),
    .blk_csc          (blk_csc),
    .blk_step         (blk_step),
    .blk_quant        (blk_quant)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string test_name, input string field,
                             input logic [127:0] expected, input logic [127:0] actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %s %s expected %0h actual %0h", test_name, field, expected, actual);
      err_count++;
    end
  endtask

  task automatic report_test(input string test_name, input int errs_before);
    if (err_count == errs_before)
    begin
      $display("test %s passed", test_name);
      tests_passed++;
    end
    else
    begin
      $display("test %s failed", test_name);
      tests_failed++;
    end
  endtask

  task automatic load_trace();
    int           fd;
    int           n;
    string        line;
    string        name;
    int           mode;
    int           flat;
    int           csc;
    int           step;
    logic [127:0] word;
    logic [7:0]   q [16];
    logic [127:0] q_all;
    fd = $fopen("bench/bitparse_trace.txt", "r");
    load_ok = (fd != 0);
    while (load_ok && !$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] == "W")
      begin
        n = $sscanf(line, "W %h", word);
        words.push_back(word);
      end
      else if (n > 1 && line[0] == "B")
      begin
        n = $sscanf(line, "B %s %d %d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, mode, flat, csc, step, q[0], q[1], q[2], q[3], q[4], q[5],
                    q[6], q[7], q[8], q[9], q[10], q[11], q[12], q[13], q[14], q[15]);
        // element 0 sits in the low byte of the packed array
        for (int i = 0; i < 16; i++)
          q_all[i*8 +: 8] = q[i];
        exp_name.push_back(name);
        exp_mode.push_back(mode);
        exp_flat.push_back(flat);
        exp_csc.push_back(csc);
        exp_step.push_back(step);
        exp_quant.push_back(q_all);
      end
    end
    if (load_ok)
      $fclose(fd);
  endtask

  // rd_en is stable by the falling edge, used at the next rising edge
  always @(negedge clk)
  begin
    rd_seen = codec_data_rd_en;
  end

  // show-ahead source, pauses start_dec at random while words remain
  always @(posedge clk)
  begin
    if (rd_seen)
      word_idx = word_idx + 1;
    if (word_idx < words.size())
    begin
      codec_data <= words[word_idx];
      if (!streaming)
        start_dec <= 1'b0;
      else if (($urandom % 4) == 0)
        start_dec <= 1'b0;
      else
        start_dec <= 1'b1;
    end
    else
    begin
      // all words gone, let the buffer drain
      codec_data <= '0;
      start_dec  <= 1'b0;
    end
  end

  // block records compared in trace order
  always @(negedge clk)
  begin : check_blk
    int errs_before;
    if (rstn && blk_vld)
    begin
      if (blk_seen >= exp_name.size())
      begin
        $display("extra block with mode %0d after the last trace record", blk_mode);
        err_count++;
      end
      else
      begin
        errs_before = err_count;
        check_value(exp_name[blk_seen], "mode", exp_mode[blk_seen], blk_mode);
        check_value(exp_name[blk_seen], "flat", exp_flat[blk_seen], blk_flat);
        check_value(exp_name[blk_seen], "csc", exp_csc[blk_seen], blk_csc);
        check_value(exp_name[blk_seen], "step", exp_step[blk_seen], blk_step);
        check_value(exp_name[blk_seen], "quant", exp_quant[blk_seen], blk_quant);
        report_test(exp_name[blk_seen], errs_before);
      end
      blk_seen++;
    end
  end

  // watchdog sized from the trace length
  initial
  begin
    wait (streaming);
    repeat ((words.size() + exp_name.size()) * 4 + DRAIN_CYCLES) @(posedge clk);
    $display("timeout, %0d of %0d blocks arrived, %0d of %0d words read",
             blk_seen, exp_name.size(), word_idx, words.size());
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    int errs_before;
    rstn       = 1'b0;
    start_dec  = 1'b0;
    codec_data = '0;
    streaming  = 1'b0;
    rd_seen    = 1'b0;
    word_idx   = 0;
    blk_seen   = 0;
    err_count  = 0;
    rand_seed  = 32'h39e5b611;
    void'($urandom(rand_seed));
    load_trace();
    if (!load_ok || words.size() == 0 || exp_name.size() == 0)
    begin
      $display("trace file missing or empty");
      $display("TESTBENCH FAILED");
      $finish;
    end
    else
    begin
      repeat (4) @(posedge clk);
      rstn <= 1'b1;
      // nothing may move before start_dec rises
      errs_before = err_count;
      repeat (IDLE_CYCLES)
      begin
        @(negedge clk);
        check_value("reset_idle", "blk_vld", 1'b0, blk_vld);
        check_value("reset_idle", "rd_en", 1'b0, codec_data_rd_en);
      end
      report_test("reset_idle", errs_before);
      streaming = 1'b1;
      wait (blk_seen >= exp_name.size());
      repeat (DRAIN_CYCLES) @(negedge clk);
      if (word_idx != words.size())
      begin
        $display("only %0d of %0d words were read", word_idx, words.size());
        err_count++;
      end
      $display("%0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, err_count);
      if (err_count == 0)
        $display("TESTBENCH PASSED");
      else
        $display("TESTBENCH FAILED");
      $finish;
    end
  end

endmodule

/* sources.f */
+incdir+design
design/bitparse_pkg.sv
design/bit_funnel.sv
design/mpp_suffix_decoder.sv
design/block_parser.sv
design/bitparse_top.sv
bench/bitparse_tb.sv

/* bench/bitparse_trace.txt */
# W <128-bit codec word in hex>, words in stream order
# B <test> <mode> <flat> <csc> <step> <residual 0 .. residual 15 in hex>
W 400123456789abcdeffedcba98765432
W 1049fe02aaa03019cc24d2b78fc0f00f
W e2fc0a95042108420c0c462ced4bf82a
W a0c07864cfc4c8be127bec3a4493f0a5
W c1e2784b6dfde2a39c579cc7d6c6935f
W 284fb2e1c8807fff005aa53cc3010204
W 08102040800000000000000000000000
B mpp_s0_rgb 2 4 0 0 01 23 45 67 89 ab cd ef fe dc ba 98 76 54 32 10
B mpp_s1_ycocg 2 4 1 1 7f 00 55 2a 01 40 33 4c 12 34 56 78 7e 03 60 0f
B same_mpp_s2 2 2 0 2 3f 00 2a 15 01 02 04 08 10 20 30 0c 11 22 33 2d
B mpp_s3_ycocg 2 4 1 3 1f 00 15 0a 01 10 03 18 0c 13 07 1c 09 12 05 1e
B xfm_flat0 0 0 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B same_xfm 0 4 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B esc_bp_flat1 1 1 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B same_bp_flat3 1 3 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B esc_xfm 0 4 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B bp_flat2 1 2 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B same_bp 1 4 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
B mpp_s4_rgb 2 4 0 4 09 03 0f 00 0a 05 0c 01 0e 02 07 08 04 0b 06 0d
B same_mpp_s5 2 3 1 5 07 00 05 02 01 06 03 04 02 05 07 01 06 03 00 07
B same_mpp_s6 2 1 0 6 03 00 01 02 02 01 00 03 01 01 03 03 00 02 02 00
B mpp_s7_ycocg 2 4 1 7 01 00 01 01 00 00 01 00 01 01 01 00 00 00 00 01
B same_mpp_s0 2 0 1 0 80 7f ff 00 5a a5 3c c3 01 02 04 08 10 20 40 80
